// ==== common/idq_defines.svh ====
// Fixed sizes for the ID queue; the slot and row index widths must be kept in step by hand

`ifndef IDQ_DEFINES_SVH
`define IDQ_DEFINES_SVH

// Bits of an element ID
`define IDQ_ID_WIDTH 2

// Bits of the stored payload and of the search mask
`define IDQ_DATA_WIDTH 16

// Number of element slots in the linked store
`define IDQ_CAPACITY 8

// Rows in the head-tail table, the smaller of 2**ID width and the capacity
`define IDQ_HT_ROWS 4

// Index widths for the slot table and the head-tail table
`define IDQ_LD_IDX_WIDTH 3
`define IDQ_HT_IDX_WIDTH 2

`endif

// ==== common/idq_pkg.sv ====
// Types follow the widths in the defines header and carry no parameters of their own

`include "idq_defines.svh"

package idq_pkg;

    // Identifier of an element
    // Elements that share an ID leave the queue in push order
    typedef logic [`IDQ_ID_WIDTH-1:0] id_t;

    // Payload of one element, also used for the search value and mask
    typedef logic [`IDQ_DATA_WIDTH-1:0] data_t;

    // Points at one slot of the linked data store
    typedef logic [`IDQ_LD_IDX_WIDTH-1:0] ld_idx_t;

    // Points at one row of the head-tail table
    typedef logic [`IDQ_HT_IDX_WIDTH-1:0] ht_idx_t;

endpackage

// ==== id_queue/idq_ctrl.sv ====
// Purely combinational; relies on the head-tail table always having a free row for a new ID

`timescale 1ns/1ps

module idq_ctrl import idq_pkg::*; (
    input  logic    inp_req_i,
    input  id_t     inp_id_i,
    input  data_t   inp_data_i,
    input  logic    oup_req_i,
    input  id_t     oup_id_i,
    input  logic    oup_pop_i,
    input  logic    full_i,
    input  ld_idx_t free_slot_i,
    input  logic    hit_i,
    input  ht_idx_t hit_row_i,
    input  ld_idx_t head_i,
    input  ld_idx_t tail_i,
    input  ht_idx_t free_row_i,
    input  data_t   head_data_i,
    input  ld_idx_t head_next_i,

    output logic    inp_gnt_o,
    output logic    oup_gnt_o,
    output data_t   oup_data_o,
    output logic    oup_data_valid_o,
    output id_t     lookup_id_o,
    output logic    ht_alloc_o,
    output logic    ht_set_tail_o,
    output logic    ht_set_head_o,
    output logic    ht_release_o,
    output ht_idx_t ht_row_o,
    output ld_idx_t ht_ptr_o,
    output logic    ld_write_o,
    output logic    ld_link_o,
    output logic    ld_release_o,
    output ld_idx_t ld_idx_o,
    output ld_idx_t ld_link_idx_o,
    output data_t   ld_data_o
);

    logic push_acc;
    logic pop;
    logic last_elem;

    // A push wins whenever a slot is free, the output port only gets the leftover cycles
    assign push_acc  = inp_req_i && !full_i;
    assign inp_gnt_o = !full_i;
    assign oup_gnt_o = oup_req_i && !push_acc;

    // Only one lookup path exists, so the winner of the arbitration owns it
    assign lookup_id_o = push_acc ? inp_id_i : oup_id_i;

    // A granted read is valid only if its ID has a row in the table
    assign oup_data_valid_o = oup_gnt_o && hit_i;
    assign oup_data_o       = oup_data_valid_o ? head_data_i : '0;

    // Removing an element needs a valid read with pop requested
    assign pop       = oup_data_valid_o && oup_pop_i;
    assign last_elem = (head_i == tail_i);

    // New payload always goes to the lowest free slot
    assign ld_data_o = inp_data_i;

    always_comb begin
        ht_alloc_o    = 1'b0;
        ht_set_tail_o = 1'b0;
        ht_set_head_o = 1'b0;
        ht_release_o  = 1'b0;
        ht_row_o      = hit_row_i;
        ht_ptr_o      = free_slot_i;
        ld_write_o    = 1'b0;
        ld_link_o     = 1'b0;
        ld_release_o  = 1'b0;
        ld_idx_o      = free_slot_i;
        ld_link_idx_o = tail_i;

        if (push_acc) begin
            ld_write_o = 1'b1;
            if (hit_i) begin
                // Known ID, so chain the new slot behind the current tail
                ld_link_o     = 1'b1;
                ht_set_tail_o = 1'b1;
            end else begin
                // First element of this ID opens a fresh row with head equal to tail
                ht_alloc_o = 1'b1;
                ht_row_o   = free_row_i;
            end
        end else if (pop) begin
            ld_release_o = 1'b1;
            ld_idx_o     = head_i;
            if (last_elem) begin
                // The sole element of this ID leaves, so the row goes back to the pool
                ht_release_o = 1'b1;
            end else begin
                ht_set_head_o = 1'b1;
                ht_ptr_o      = head_next_i;
            end
        end
    end

endmodule

// ==== id_queue/idq_head_tail.sv ====
// One row per live ID; a lookup that matches several rows is not expected and ORs their indices

`timescale 1ns/1ps

`include "idq_defines.svh"

module idq_head_tail import idq_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  id_t     lookup_id_i,
    input  logic    alloc_i,
    input  logic    set_tail_i,
    input  logic    set_head_i,
    input  logic    release_i,
    input  ht_idx_t row_i,
    input  ld_idx_t ptr_i,
    output logic    hit_o,
    output ht_idx_t hit_row_o,
    output ld_idx_t head_o,
    output ld_idx_t tail_o,
    output ht_idx_t free_row_o
);

    id_t     id_q   [`IDQ_HT_ROWS];
    ld_idx_t head_q [`IDQ_HT_ROWS];
    ld_idx_t tail_q [`IDQ_HT_ROWS];
    logic    [`IDQ_HT_ROWS-1:0] free_q;
    logic    [`IDQ_HT_ROWS-1:0] match;

    // Compare the lookup ID against every occupied row
    always_comb begin
        for (int r = 0; r < `IDQ_HT_ROWS; r++) begin
            match[r] = !free_q[r] && (id_q[r] == lookup_id_i);
        end
    end

    assign hit_o = |match;

    // Turn the one-hot match into a row index
    always_comb begin
        hit_row_o = '0;
        for (int r = 0; r < `IDQ_HT_ROWS; r++) begin
            if (match[r]) begin
                hit_row_o = hit_row_o | ht_idx_t'(r);
            end
        end
    end

    // Lowest free row, scanned from the top so the smallest index wins
    always_comb begin
        free_row_o = '0;
        for (int r = `IDQ_HT_ROWS - 1; r >= 0; r--) begin
            if (free_q[r]) begin
                free_row_o = ht_idx_t'(r);
            end
        end
    end

    assign head_o = head_q[hit_row_o];
    assign tail_o = tail_q[hit_row_o];

    // The controller issues at most one command per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
            for (int r = 0; r < `IDQ_HT_ROWS; r++) begin
                id_q[r]   <= '0;
                head_q[r] <= '0;
                tail_q[r] <= '0;
            end
        end else if (alloc_i) begin
            free_q[row_i] <= 1'b0;
            id_q[row_i]   <= lookup_id_i;
            head_q[row_i] <= ptr_i;
            tail_q[row_i] <= ptr_i;
        end else if (set_tail_i) begin
            tail_q[row_i] <= ptr_i;
        end else if (set_head_i) begin
            head_q[row_i] <= ptr_i;
        end else if (release_i) begin
            free_q[row_i] <= 1'b1;
        end
    end

endmodule

// ==== id_queue/idq_link_store.sv ====
// Payload and next pointers have no reset; only the free flags are trusted after reset

`timescale 1ns/1ps

`include "idq_defines.svh"

module idq_link_store import idq_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    write_i,
    input  logic    link_i,
    input  logic    release_i,
    input  ld_idx_t idx_i,
    input  ld_idx_t link_idx_i,
    input  data_t   data_i,
    input  ld_idx_t rd_idx_i,
    output logic    full_o,
    output ld_idx_t free_slot_o,
    output data_t   rd_data_o,
    output ld_idx_t rd_next_o,
    input  logic    exists_req_i,
    input  data_t   exists_data_i,
    input  data_t   exists_mask_i,
    output logic    exists_o
);

    data_t   data_q [`IDQ_CAPACITY];
    ld_idx_t next_q [`IDQ_CAPACITY];
    logic    [`IDQ_CAPACITY-1:0] free_q;
    logic    [`IDQ_CAPACITY-1:0] exists_match;

    // The store is full once no slot is marked free
    assign full_o = ~|free_q;

    // Lowest free slot, the scan runs downwards so index 0 has priority
    always_comb begin
        free_slot_o = '0;
        for (int s = `IDQ_CAPACITY - 1; s >= 0; s--) begin
            if (free_q[s]) begin
                free_slot_o = ld_idx_t'(s);
            end
        end
    end

    // Read port for the head of the selected ID
    assign rd_data_o = data_q[rd_idx_i];
    assign rd_next_o = next_q[rd_idx_i];

    // Masked compare per slot
    // Bits cleared in the mask are ignored and free slots never match
    always_comb begin
        for (int s = 0; s < `IDQ_CAPACITY; s++) begin
            exists_match[s] = !free_q[s] &&
                (((data_q[s] ^ exists_data_i) & exists_mask_i) == '0);
        end
    end

    assign exists_o = exists_req_i && (|exists_match);

    // Free flags are the only control state in the store
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
        end else if (write_i) begin
            free_q[idx_i] <= 1'b0;
        end else if (release_i) begin
            free_q[idx_i] <= 1'b1;
        end
    end

    // A push to a known ID writes the new slot and links the old tail in the same cycle
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            data_q[idx_i] <= data_i;
        end
        if (link_i) begin
            next_q[link_idx_i] <= idx_i;
        end
    end

endmodule

// ==== id_queue/id_queue_top.sv ====
// Half-bandwidth ID queue; push has priority and only one of push or output happens per cycle

`timescale 1ns/1ps

module id_queue_top import idq_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  inp_req_i,
    input  id_t   inp_id_i,
    input  data_t inp_data_i,
    output logic  inp_gnt_o,

    input  logic  oup_req_i,
    input  id_t   oup_id_i,
    input  logic  oup_pop_i,
    output logic  oup_gnt_o,
    output data_t oup_data_o,
    output logic  oup_data_valid_o,

    input  logic  exists_req_i,
    input  data_t exists_data_i,
    input  data_t exists_mask_i,
    output logic  exists_o
);

    // Lookup and command signals from the controller
    id_t     lookup_id;
    logic    ht_alloc;
    logic    ht_set_tail;
    logic    ht_set_head;
    logic    ht_release;
    ht_idx_t ht_row;
    ld_idx_t ht_ptr;
    logic    ld_write;
    logic    ld_link;
    logic    ld_release;
    ld_idx_t ld_idx;
    ld_idx_t ld_link_idx;
    data_t   ld_data;

    // Status returned by the head-tail table
    logic    hit;
    ht_idx_t hit_row;
    ld_idx_t head;
    ld_idx_t tail;
    ht_idx_t free_row;

    // Status returned by the linked store
    logic    full;
    ld_idx_t free_slot;
    data_t   head_data;
    ld_idx_t head_next;

    idq_ctrl i_idq_ctrl (
        .inp_req_i        ( inp_req_i        ),
        .inp_id_i         ( inp_id_i         ),
        .inp_data_i       ( inp_data_i       ),
        .oup_req_i        ( oup_req_i        ),
        .oup_id_i         ( oup_id_i         ),
        .oup_pop_i        ( oup_pop_i        ),
        .full_i           ( full             ),
        .free_slot_i      ( free_slot        ),
        .hit_i            ( hit              ),
        .hit_row_i        ( hit_row          ),
        .head_i           ( head             ),
        .tail_i           ( tail             ),
        .free_row_i       ( free_row         ),
        .head_data_i      ( head_data        ),
        .head_next_i      ( head_next        ),
        .inp_gnt_o        ( inp_gnt_o        ),
        .oup_gnt_o        ( oup_gnt_o        ),
        .oup_data_o       ( oup_data_o       ),
        .oup_data_valid_o ( oup_data_valid_o ),
        .lookup_id_o      ( lookup_id        ),
        .ht_alloc_o       ( ht_alloc         ),
        .ht_set_tail_o    ( ht_set_tail      ),
        .ht_set_head_o    ( ht_set_head      ),
        .ht_release_o     ( ht_release       ),
        .ht_row_o         ( ht_row           ),
        .ht_ptr_o         ( ht_ptr           ),
        .ld_write_o       ( ld_write         ),
        .ld_link_o        ( ld_link          ),
        .ld_release_o     ( ld_release       ),
        .ld_idx_o         ( ld_idx           ),
        .ld_link_idx_o    ( ld_link_idx      ),
        .ld_data_o        ( ld_data          )
    );

    idq_head_tail i_idq_head_tail (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .lookup_id_i ( lookup_id   ),
        .alloc_i     ( ht_alloc    ),
        .set_tail_i  ( ht_set_tail ),
        .set_head_i  ( ht_set_head ),
        .release_i   ( ht_release  ),
        .row_i       ( ht_row      ),
        .ptr_i       ( ht_ptr      ),
        .hit_o       ( hit         ),
        .hit_row_o   ( hit_row     ),
        .head_o      ( head        ),
        .tail_o      ( tail        ),
        .free_row_o  ( free_row    )
    );

    // The read port of the store always follows the head of the looked-up ID
    idq_link_store i_idq_link_store (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .write_i       ( ld_write      ),
        .link_i        ( ld_link       ),
        .release_i     ( ld_release    ),
        .idx_i         ( ld_idx        ),
        .link_idx_i    ( ld_link_idx   ),
        .data_i        ( ld_data       ),
        .rd_idx_i      ( head          ),
        .full_o        ( full          ),
        .free_slot_o   ( free_slot     ),
        .rd_data_o     ( head_data     ),
        .rd_next_o     ( head_next     ),
        .exists_req_i  ( exists_req_i  ),
        .exists_data_i ( exists_data_i ),
        .exists_mask_i ( exists_mask_i ),
        .exists_o      ( exists_o      )
    );

endmodule

// ==== verif/idq_assert.sv ====
// Port-level protocol checks for id_queue_top; they are silent while the reset is active

`timescale 1ns/1ps

module idq_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic inp_req_i,
    input logic inp_gnt_i,
    input logic oup_gnt_i,
    input logic oup_data_valid_i,
    input logic exists_req_i,
    input logic exists_i
);

    // Read data is only ever valid in a granted output cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) oup_data_valid_i |-> oup_gnt_i)
        else $error("oup_data_valid_o rose without oup_gnt_o");

    // Only one of push and output may be served per cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        inp_req_i |-> !(inp_gnt_i && oup_gnt_i))
        else $error("push and output were granted in the same cycle");

    // A search result needs a search request
    assert property (@(posedge clk_i) disable iff (!rst_ni) exists_i |-> exists_req_i)
        else $error("exists_o rose without exists_req_i");

endmodule

bind id_queue_top idq_assert i_idq_assert (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .inp_req_i        ( inp_req_i        ),
    .inp_gnt_i        ( inp_gnt_o        ),
    .oup_gnt_i        ( oup_gnt_o        ),
    .oup_data_valid_i ( oup_data_valid_o ),
    .exists_req_i     ( exists_req_i     ),
    .exists_i         ( exists_o         )
);

// ==== verif/tb_id_queue.sv ====
// Directed tests for id_queue_top; inputs change on rising edges, outputs are sampled on falling edges

`timescale 1ns/1ps

`include "idq_defines.svh"

module tb_id_queue import idq_pkg::*; ();

    localparam int TIMEOUT = 50;

    logic  clk;
    logic  rst_n;
    logic  inp_req;
    id_t   inp_id;
    data_t inp_data;
    logic  inp_gnt;
    logic  oup_req;
    id_t   oup_id;
    logic  oup_pop;
    logic  oup_gnt;
    data_t oup_data;
    logic  oup_valid;
    logic  exists_req;
    data_t exists_data;
    data_t exists_mask;
    logic  exists;

    // Model of the queue, one FIFO per ID
    data_t model_q [`IDQ_HT_ROWS][$];

    logic [15:0] lfsr_q;
    string       cur_test;
    int          err_count;
    int          test_count;
    int          fail_count;
    int          test_start_err;
    // Set once a port never granted, the model can no longer be trusted to drain
    logic        timed_out;

    id_queue_top i_id_queue_top (
        .clk_i            ( clk         ),
        .rst_ni           ( rst_n       ),
        .inp_req_i        ( inp_req     ),
        .inp_id_i         ( inp_id      ),
        .inp_data_i       ( inp_data    ),
        .inp_gnt_o        ( inp_gnt     ),
        .oup_req_i        ( oup_req     ),
        .oup_id_i         ( oup_id      ),
        .oup_pop_i        ( oup_pop     ),
        .oup_gnt_o        ( oup_gnt     ),
        .oup_data_o       ( oup_data    ),
        .oup_data_valid_o ( oup_valid   ),
        .exists_req_i     ( exists_req  ),
        .exists_data_i    ( exists_data ),
        .exists_mask_i    ( exists_mask ),
        .exists_o         ( exists      )
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step for every bit that is taken
    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[`IDQ_DATA_WIDTH-2:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // True if the model holds an element that agrees with the value on all masked bits
    function automatic logic model_has_match(input data_t value, input data_t mask);
        logic found;
        found = 1'b0;
        for (int i = 0; i < `IDQ_HT_ROWS; i++) begin
            for (int k = 0; k < model_q[i].size(); k++) begin
                if ((model_q[i][k] & mask) == (value & mask)) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("MISMATCH %s (%s): expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s (%s): expected %b, actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_start_err = err_count;
    endtask

    task automatic finish_test();
        test_count++;
        if (err_count == test_start_err) begin
            $display("[ok]     %s", cur_test);
        end else begin
            fail_count++;
            $display("[failed] %s with %0d errors", cur_test, err_count - test_start_err);
        end
    endtask

    // Holds the push request until the queue grants it, then updates the model
    task automatic push_elem(input id_t id, input data_t data);
        int   waited;
        logic granted;
        waited = 0;
        @(posedge clk);
        inp_req  <= 1'b1;
        inp_id   <= id;
        inp_data <= data;
        @(negedge clk);
        while (!inp_gnt && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        granted = inp_gnt;
        if (!granted) begin
            $display("Timeout in %s: the push port never granted", cur_test);
            err_count++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        inp_req <= 1'b0;
        if (granted) begin
            model_q[id].push_back(data);
        end
    endtask

    // Reads one ID, compares with the model head, and pops it if asked
    task automatic read_check(input id_t id, input logic pop);
        int   waited;
        logic exp_valid;
        logic granted;
        waited = 0;
        @(posedge clk);
        oup_req <= 1'b1;
        oup_id  <= id;
        oup_pop <= pop;
        @(negedge clk);
        while (!oup_gnt && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        exp_valid = (model_q[id].size() != 0);
        granted   = oup_gnt;
        if (!granted) begin
            $display("Timeout in %s: the output port never granted", cur_test);
            err_count++;
            timed_out = 1'b1;
        end else begin
            check_bit($sformatf("valid of ID %0d", id), exp_valid, oup_valid);
            if (exp_valid) begin
                check_data($sformatf("head of ID %0d", id), model_q[id][0], oup_data);
            end
        end
        @(posedge clk);
        oup_req <= 1'b0;
        oup_pop <= 1'b0;
        if (pop && exp_valid && granted) begin
            void'(model_q[id].pop_front());
        end
    endtask

    task automatic search_check(input data_t value, input data_t mask);
        @(posedge clk);
        exists_req  <= 1'b1;
        exists_data <= value;
        exists_mask <= mask;
        @(negedge clk);
        check_bit($sformatf("search %h mask %h", value, mask),
            model_has_match(value, mask), exists);
        @(posedge clk);
        exists_req <= 1'b0;
    endtask

    // Pops every ID until the model says it is empty
    task automatic drain_all();
        for (int i = 0; i < `IDQ_HT_ROWS; i++) begin
            while (model_q[i].size() != 0 && !timed_out) begin
                read_check(id_t'(i), 1'b1);
            end
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge clk);
        check_bit("inp_gnt after reset", 1'b1, inp_gnt);
        for (int i = 0; i < `IDQ_HT_ROWS; i++) begin
            read_check(id_t'(i), 1'b0);
        end
        // A zero mask matches any stored element, so this only fails on a stale slot
        search_check('0, '0);
        search_check(16'h0000, '1);
        finish_test();
    endtask

    task automatic test_per_id_order();
        start_test("per_id_order");
        for (int i = 0; i < `IDQ_CAPACITY; i++) begin
            push_elem(id_t'(i % `IDQ_HT_ROWS), rand_bits(`IDQ_DATA_WIDTH));
        end
        for (int i = `IDQ_HT_ROWS - 1; i >= 0; i--) begin
            while (model_q[i].size() != 0 && !timed_out) begin
                read_check(id_t'(i), 1'b1);
            end
            // The emptied ID must now read as invalid
            read_check(id_t'(i), 1'b0);
        end
        finish_test();
    endtask

    task automatic test_peek();
        start_test("non_destructive_read");
        for (int i = 0; i < 3; i++) begin
            push_elem(2'd1, rand_bits(`IDQ_DATA_WIDTH));
        end
        read_check(2'd1, 1'b0);
        read_check(2'd1, 1'b0);
        read_check(2'd1, 1'b1);
        read_check(2'd1, 1'b0);
        drain_all();
        finish_test();
    endtask

    task automatic test_full();
        id_t   hold_id;
        data_t hold_data;
        int    pop_id;
        start_test("full_backpressure");
        for (int i = 0; i < `IDQ_CAPACITY; i++) begin
            push_elem(id_t'(rand_bits(`IDQ_ID_WIDTH)), rand_bits(`IDQ_DATA_WIDTH));
        end
        hold_id   = id_t'(rand_bits(`IDQ_ID_WIDTH));
        hold_data = rand_bits(`IDQ_DATA_WIDTH);
        @(posedge clk);
        inp_req  <= 1'b1;
        inp_id   <= hold_id;
        inp_data <= hold_data;
        repeat (2) begin
            @(negedge clk);
            check_bit("inp_gnt while full", 1'b0, inp_gnt);
        end
        pop_id = 0;
        for (int i = `IDQ_HT_ROWS - 1; i >= 0; i--) begin
            if (model_q[i].size() != 0) begin
                pop_id = i;
            end
        end
        // The blocked push stays requested while the output port pops
        read_check(id_t'(pop_id), 1'b1);
        @(negedge clk);
        check_bit("inp_gnt after pop", 1'b1, inp_gnt);
        @(posedge clk);
        inp_req <= 1'b0;
        model_q[hold_id].push_back(hold_data);
        drain_all();
        finish_test();
    endtask

    task automatic test_push_priority();
        data_t value;
        start_test("push_priority");
        value = rand_bits(`IDQ_DATA_WIDTH);
        @(posedge clk);
        inp_req  <= 1'b1;
        inp_id   <= 2'd3;
        inp_data <= value;
        oup_req  <= 1'b1;
        oup_id   <= 2'd3;
        oup_pop  <= 1'b0;
        @(negedge clk);
        check_bit("inp_gnt with both requests", 1'b1, inp_gnt);
        check_bit("oup_gnt with both requests", 1'b0, oup_gnt);
        @(posedge clk);
        inp_req <= 1'b0;
        model_q[3].push_back(value);
        // Once the push is gone the waiting read is served
        @(negedge clk);
        check_bit("oup_gnt after push", 1'b1, oup_gnt);
        check_bit("valid after push", 1'b1, oup_valid);
        check_data("head after push", value, oup_data);
        @(posedge clk);
        oup_req <= 1'b0;
        drain_all();
        finish_test();
    endtask

    task automatic test_masked_search();
        start_test("masked_search");
        push_elem(2'd0, 16'hA5C3);
        push_elem(2'd1, 16'h1234);
        push_elem(2'd2, 16'hFF00);
        search_check(16'hA500, 16'hFF00);
        search_check(16'hA600, 16'hFF00);
        search_check(16'h0034, 16'h00FF);
        search_check(16'h0035, 16'h00FF);
        search_check(16'hF000, 16'hF00F);
        search_check(16'h1234, 16'hFFFF);
        search_check(16'h1235, 16'hFFFF);
        search_check(rand_bits(`IDQ_DATA_WIDTH), 16'h0003);
        drain_all();
        search_check(16'hA5C3, 16'hFFFF);
        finish_test();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        inp_req     = 1'b0;
        inp_id      = '0;
        inp_data    = '0;
        oup_req     = 1'b0;
        oup_id      = '0;
        oup_pop     = 1'b0;
        exists_req  = 1'b0;
        exists_data = '0;
        exists_mask = '0;
        lfsr_q      = 16'h0001;
        err_count   = 0;
        test_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_per_id_order();
        test_peek();
        test_full();
        test_push_priority();
        test_masked_search();

        repeat (2) @(posedge clk);
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
            test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/idq_pkg.sv
id_queue/idq_ctrl.sv
id_queue/idq_head_tail.sv
id_queue/idq_link_store.sv
id_queue/id_queue_top.sv
verif/idq_assert.sv
verif/tb_id_queue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ID queue testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f compile.f --top-module tb_id_queue -o sim_id_queue \
    && ./obj_dir/sim_id_queue > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed!" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
